// ==== ctb_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "issue_unit_consts.svh"

module ctb_pipe (
  input  logic                                          clock,
  input  logic                                          reset,
  input  issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0]  issue_uop,
  output issue_unit_pkg::ctb_t      [`ISSUE_WIDTH-1:0]  ctb,
  output issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0]  complete_uop
);

  // stands in for the execution units, fixed latency and always accepting
  issue_unit_pkg::micro_op_t [`EX_LATENCY-1:0][`ISSUE_WIDTH-1:0] stage;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < `EX_LATENCY; s++) begin
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
          stage[s][k].valid <= 1'b0;
        end
      end
    end else begin
      stage[0] <= issue_uop;
      for (int s = 1; s < `EX_LATENCY; s++) begin
        stage[s] <= stage[s-1];
      end
    end
  end

  assign complete_uop = stage[`EX_LATENCY-1];

  // ops without a destination complete but broadcast nothing
  always_comb begin
    for (int k = 0; k < `ISSUE_WIDTH; k++) begin
      ctb[k].valid     = complete_uop[k].valid && complete_uop[k].rd_valid;
      ctb[k].prf_index = complete_uop[k].rd_index;
    end
  end

endmodule

`default_nettype wire

// ==== issue_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "issue_unit_consts.svh"

module issue_queue (
  input  logic                                              clock,
  input  logic                                              reset,
  input  issue_unit_pkg::ctb_t      [`ISSUE_WIDTH-1:0]      ctb,
  input  issue_unit_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]   dispatch_uop,
  output issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0]      issue_uop,
  output logic [`CREDIT_SIZE-1:0]                           credit_return
);

  logic [`IQ_SIZE-1:0] free;
  logic [`IQ_SIZE-1:0] ready;
  logic [`IQ_SIZE-1:0] load;
  logic [`IQ_SIZE-1:0] clear;
  issue_unit_pkg::micro_op_t [`IQ_SIZE-1:0] uop_to_slot;
  issue_unit_pkg::micro_op_t [`IQ_SIZE-1:0] slot_uop;
  issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0] issue_next;
  logic [`DISPATCH_WIDTH-1:0][`IQ_SIZE-1:0] gnt_bus_in;
  logic [`ISSUE_WIDTH-1:0][`IQ_SIZE-1:0] gnt_bus_out;
  logic dispatch_lost;
  logic [`CREDIT_SIZE-1:0] load_count;
  logic [`CREDIT_SIZE-1:0] issue_count;
  logic [`CREDIT_SIZE-1:0] occupancy;

  for (genvar j = 0; j < `IQ_SIZE; j++) begin : g_slot
    issue_slot slot (
      .clock  (clock),
      .reset  (reset),
      .load   (load[j]),
      .clear  (clear[j]),
      .ctb    (ctb),
      .uop_in (uop_to_slot[j]),
      .uop    (slot_uop[j]),
      .ready  (ready[j]),
      .free   (free[j])
    );
  end

  // lowest free slots first
  psel_gen #(
    .REQS   (`DISPATCH_WIDTH),
    .WIDTH  (`IQ_SIZE)
  ) input_selector (
    .req      (free),
    .gnt      (),
    .gnt_bus  (gnt_bus_in),
    .empty    ()
  );

  // the n-th valid lane goes to the n-th granted slot
  always_comb begin
    int rank;
    rank          = 0;
    load          = '0;
    uop_to_slot   = '0;
    dispatch_lost = 1'b0;
    load_count    = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (dispatch_uop[i].valid) begin
        if (gnt_bus_in[rank] == '0) begin
          dispatch_lost = 1'b1;
        end
        for (int j = 0; j < `IQ_SIZE; j++) begin
          if (gnt_bus_in[rank][j]) begin
            load[j]        = 1'b1;
            uop_to_slot[j] = dispatch_uop[i];
          end
        end
        rank       = rank + 1;
        load_count = load_count + 1'b1;
      end
    end
  end

  // lowest ready slots issue first, at most ISSUE_WIDTH per cycle
  psel_gen #(
    .REQS   (`ISSUE_WIDTH),
    .WIDTH  (`IQ_SIZE)
  ) output_selector (
    .req      (ready),
    .gnt      (clear),
    .gnt_bus  (gnt_bus_out),
    .empty    ()
  );

  always_comb begin
    issue_next  = '0;
    issue_count = '0;
    for (int k = 0; k < `ISSUE_WIDTH; k++) begin
      for (int j = 0; j < `IQ_SIZE; j++) begin
        if (gnt_bus_out[k][j]) begin
          issue_next[k] = slot_uop[j];
        end
      end
    end
    for (int j = 0; j < `IQ_SIZE; j++) begin
      issue_count = issue_count + {{(`CREDIT_SIZE-1){1'b0}}, clear[j]};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < `ISSUE_WIDTH; k++) begin
        issue_uop[k].valid <= 1'b0;
      end
      credit_return <= '0;
      occupancy     <= '0;
    end else begin
      issue_uop     <= issue_next;
      // one credit back per slot freed this edge
      credit_return <= issue_count;
      occupancy     <= occupancy + load_count - issue_count;
    end
  end

  // dispatch must stay within its credits
  assert property (@(posedge clock) disable iff (reset) !dispatch_lost)
    else $error("issue_queue: valid dispatch lane found no free slot");

  assert property (@(posedge clock) disable iff (reset) occupancy <= `IQ_SIZE)
    else $error("issue_queue: occupancy %0d exceeds queue size", occupancy);

endmodule

`default_nettype wire

// ==== issue_slot.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "issue_unit_consts.svh"

module issue_slot (
  input  logic                                        clock,
  input  logic                                        reset,
  input  logic                                        load,
  input  logic                                        clear,
  input  issue_unit_pkg::ctb_t [`ISSUE_WIDTH-1:0]     ctb,
  input  issue_unit_pkg::micro_op_t                   uop_in,
  output issue_unit_pkg::micro_op_t                   uop,
  output logic                                        ready,
  output logic                                        free
);

  issue_unit_pkg::micro_op_t held_uop;
  logic occupied;
  logic rs1_ready;
  logic rs2_ready;
  logic rs1_ready_at_load;
  logic rs2_ready_at_load;

  // true when any valid ctb lane carries this tag
  function automatic logic tag_hit(input logic [`PRF_INDEX_SIZE-1:0] index);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `ISSUE_WIDTH; i++) begin
      hit = hit | (ctb[i].valid && (ctb[i].prf_index == index));
    end
    return hit;
  endfunction

  // unused or already written sources start ready, as do same-cycle broadcasts
  assign rs1_ready_at_load = !uop_in.rs1_valid || !uop_in.rs1_pending ||
                             tag_hit(uop_in.rs1_index);
  assign rs2_ready_at_load = !uop_in.rs2_valid || !uop_in.rs2_pending ||
                             tag_hit(uop_in.rs2_index);

  always_ff @(posedge clock) begin
    if (reset || clear) begin
      occupied  <= 1'b0;
      rs1_ready <= 1'b0;
      rs2_ready <= 1'b0;
    end else if (load) begin
      occupied  <= 1'b1;
      rs1_ready <= rs1_ready_at_load;
      rs2_ready <= rs2_ready_at_load;
    end else begin
      // snoop the ctb while waiting
      rs1_ready <= rs1_ready || tag_hit(held_uop.rs1_index);
      rs2_ready <= rs2_ready || tag_hit(held_uop.rs2_index);
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      held_uop <= uop_in;
    end
  end

  always_comb begin
    uop       = held_uop;
    uop.valid = occupied;
  end

  assign ready = occupied && rs1_ready && rs2_ready;
  assign free  = !occupied;

  // the input selector must only steer ops into empty slots
  assert property (@(posedge clock) disable iff (reset) load |-> !occupied)
    else $error("issue_slot: load while the slot is occupied");

endmodule

`default_nettype wire

// ==== issue_unit.f ====
+incdir+.
issue_unit_pkg.sv
psel_gen.sv
issue_slot.sv
issue_queue.sv
ctb_pipe.sv
issue_unit.sv
tb_clock_gen.sv
tb_issue_unit.sv

// ==== issue_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "issue_unit_consts.svh"

module issue_unit (
  input  logic                                              clock,
  input  logic                                              reset,
  input  issue_unit_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]   dispatch_uop,
  output issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0]      issue_uop,
  output logic [`CREDIT_SIZE-1:0]                           credit_return,
  output issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0]      complete_uop
);

  // wakeup tags fed back from execution into every slot
  issue_unit_pkg::ctb_t [`ISSUE_WIDTH-1:0] ctb;

  issue_queue i_issue_queue (
    .clock          (clock),
    .reset          (reset),
    .ctb            (ctb),
    .dispatch_uop   (dispatch_uop),
    .issue_uop      (issue_uop),
    .credit_return  (credit_return)
  );

  ctb_pipe i_ctb_pipe (
    .clock          (clock),
    .reset          (reset),
    .issue_uop      (issue_uop),
    .ctb            (ctb),
    .complete_uop   (complete_uop)
  );

endmodule

`default_nettype wire

// ==== issue_unit_consts.svh ====
`ifndef ISSUE_UNIT_CONSTS_SVH
`define ISSUE_UNIT_CONSTS_SVH

// issue queue depth, also the credits dispatch starts with
`define IQ_SIZE 8

// micro-ops accepted from rename and dispatch per cycle
`define DISPATCH_WIDTH 4

// issue lanes, one ctb lane per issue lane
`define ISSUE_WIDTH 3

// physical register tag width
`define PRF_INDEX_SIZE 6

// op identifier carried through for tracking
`define ROB_TAG_SIZE 5

// cycles from an issue output to its ctb broadcast
`define EX_LATENCY 2

// credit count width, must hold the value IQ_SIZE
`define CREDIT_SIZE 4

`endif

// ==== issue_unit_pkg.sv ====
`default_nettype none

`include "issue_unit_consts.svh"

package issue_unit_pkg;

  // integer ALU operations
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_sll = 3'd5,
    op_srl = 3'd6,
    op_slt = 3'd7
  } op_e;

  // pending flags mark sources still waiting on a producer at dispatch
  typedef struct packed {
    logic                       valid;
    op_e                        op;
    logic [`ROB_TAG_SIZE-1:0]   rob_tag;
    logic                       rd_valid;
    logic [`PRF_INDEX_SIZE-1:0] rd_index;
    logic                       rs1_valid;
    logic                       rs1_pending;
    logic [`PRF_INDEX_SIZE-1:0] rs1_index;
    logic                       rs2_valid;
    logic                       rs2_pending;
    logic [`PRF_INDEX_SIZE-1:0] rs2_index;
  } micro_op_t;

  // one lane of the common tag bus
  typedef struct packed {
    logic                       valid;
    logic [`PRF_INDEX_SIZE-1:0] prf_index;
  } ctb_t;

endpackage

`default_nettype wire

// ==== psel_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module psel_gen #(
  parameter int REQS  = 2,
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]            req,
  output logic [WIDTH-1:0]            gnt,
  output logic [REQS-1:0][WIDTH-1:0]  gnt_bus,
  output logic                        empty
);

  logic overlap;

  // grant k takes the lowest request left after grants 0 to k-1
  always_comb begin
    logic [WIDTH-1:0] remaining;
    remaining = req;
    gnt = '0;
    for (int k = 0; k < REQS; k++) begin
      // isolate the lowest set bit
      gnt_bus[k] = remaining & (~remaining + 1'b1);
      remaining  = remaining & ~gnt_bus[k];
      gnt        = gnt | gnt_bus[k];
    end
  end

  assign empty = ~|req;

  // pairwise check of the grant rows
  always_comb begin
    overlap = 1'b0;
    for (int i = 0; i < REQS; i++) begin
      for (int j = i + 1; j < REQS; j++) begin
        overlap = overlap | (|(gnt_bus[i] & gnt_bus[j]));
      end
    end
  end

  // no two grant rows may select the same requester
  always_comb begin
    assert (!overlap) else $error("psel_gen: two grants select the same requester");
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the issue_unit testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_issue_unit -f issue_unit.f -o sim_issue_unit \
  && ./obj_dir/sim_issue_unit \
  || { echo "issue_unit simulation failed"; exit 1; }

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 2,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // reset drops on a falling edge like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_issue_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "issue_unit_consts.svh"

module tb_issue_unit;

  typedef logic [`CREDIT_SIZE-1:0] count_t;
  typedef logic [`PRF_INDEX_SIZE-1:0] prf_t;

  localparam int num_tags = 1 << `ROB_TAG_SIZE;
  localparam int chain_ops = 24;
  // cycle budgets of the tests
  localparam int reset_budget = 16 + 8;
  localparam int independent_budget = 20;
  localparam int wakeup_budget = 40;
  localparam int credit_budget = 40;
  localparam int chain_budget = 250;
  localparam int watchdog_ns = (reset_budget + independent_budget + wakeup_budget +
                                credit_budget + chain_budget) * 4 * 2;

  logic clock;
  logic reset;
  issue_unit_pkg::micro_op_t [`DISPATCH_WIDTH-1:0] dispatch_uop;
  issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0] issue_uop;
  issue_unit_pkg::micro_op_t [`ISSUE_WIDTH-1:0] complete_uop;
  count_t credit_return;

  // scoreboard indexed by rob_tag
  int cycle;
  int credits;
  int open_ops;
  bit outstanding [num_tags];
  bit issued [num_tags];
  bit completed [num_tags];
  int issue_cycle [num_tags];
  int complete_cycle [num_tags];
  int prod1 [num_tags];
  int prod2 [num_tags];
  issue_unit_pkg::micro_op_t sent_uop [num_tags];

  tb_clock_gen i_tb_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  issue_unit i_issue_unit (
    .clock         (clock),
    .reset         (reset),
    .dispatch_uop  (dispatch_uop),
    .issue_uop     (issue_uop),
    .credit_return (credit_return),
    .complete_uop  (complete_uop)
  );

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_uop(input string name, input issue_unit_pkg::micro_op_t actual,
                           input issue_unit_pkg::micro_op_t expected);
    if (actual.valid !== expected.valid || (expected.valid && actual !== expected)) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input count_t actual, input count_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic clear_board();
    for (int t = 0; t < num_tags; t++) begin
      outstanding[t] = 1'b0;
      issued[t] = 1'b0;
      completed[t] = 1'b0;
      prod1[t] = -1;
      prod2[t] = -1;
    end
  endtask

  // a tag still on the ctb this cycle counts as pending, so the slot sees it at load
  function automatic logic pending_on(input int p);
    if (p < 0) begin
      return 1'b0;
    end
    return !completed[p] || complete_cycle[p] == cycle;
  endfunction

  function automatic logic ready_by(input int p);
    if (p < 0) begin
      return 1'b1;
    end
    return issued[p] && cycle >= issue_cycle[p] + `EX_LATENCY + 2;
  endfunction

  // rd_index equals rob_tag so every producer tag is unique
  task automatic stage_op(input int lane, input int tag, input int p1, input int p2);
    issue_unit_pkg::micro_op_t u;
    if (credits == 0) begin
      $display("dispatch tried to send op %0d with no credit left", tag);
      abort_run();
    end
    u.valid       = 1'b1;
    u.op          = issue_unit_pkg::op_e'(3'($urandom));
    u.rob_tag     = `ROB_TAG_SIZE'(tag);
    u.rd_valid    = 1'b1;
    u.rd_index    = prf_t'(tag);
    u.rs1_valid   = 1'b1;
    u.rs1_pending = pending_on(p1);
    u.rs1_index   = (p1 >= 0) ? prf_t'(p1) : prf_t'($urandom);
    u.rs2_valid   = 1'b1;
    u.rs2_pending = pending_on(p2);
    u.rs2_index   = (p2 >= 0) ? prf_t'(p2) : prf_t'($urandom);
    dispatch_uop[lane] = u;
    sent_uop[tag] = u;
    prod1[tag] = p1;
    prod2[tag] = p2;
    outstanding[tag] = 1'b1;
    issued[tag] = 1'b0;
    completed[tag] = 1'b0;
    credits--;
    open_ops++;
  endtask

  // one clock edge, then the outputs are checked at the falling edge
  task automatic step_cycle();
    int t;
    @(posedge clock);
    cycle++;
    @(negedge clock);
    dispatch_uop = '0;
    if (int'(credit_return) > `ISSUE_WIDTH) begin
      $display("%0d credits returned in one cycle", credit_return);
      abort_run();
    end
    credits = credits + int'(credit_return);
    if (credits > `IQ_SIZE) begin
      $display("dispatch holds %0d credits, more than the queue has slots", credits);
      abort_run();
    end
    for (int k = 0; k < `ISSUE_WIDTH; k++) begin
      if (issue_uop[k].valid) begin
        t = int'(issue_uop[k].rob_tag);
        if (!outstanding[t] || issued[t]) begin
          $display("op %0d issued twice or without being dispatched", t);
          abort_run();
        end
        check_uop($sformatf("issue_uop[%0d]", k), issue_uop[k], sent_uop[t]);
        issued[t] = 1'b1;
        issue_cycle[t] = cycle;
        if (!ready_by(prod1[t]) || !ready_by(prod2[t])) begin
          $display("op %0d issued too soon after one of its producers", t);
          abort_run();
        end
      end
    end
    for (int k = 0; k < `ISSUE_WIDTH; k++) begin
      if (complete_uop[k].valid) begin
        t = int'(complete_uop[k].rob_tag);
        if (!issued[t] || completed[t] || cycle != issue_cycle[t] + `EX_LATENCY) begin
          $display("op %0d completed at cycle %0d, not %0d cycles after its issue",
                   t, cycle, `EX_LATENCY);
          abort_run();
        end
        check_uop($sformatf("complete_uop[%0d]", k), complete_uop[k], sent_uop[t]);
        completed[t] = 1'b1;
        complete_cycle[t] = cycle;
        outstanding[t] = 1'b0;
        open_ops--;
      end
    end
  endtask

  task automatic await_issue(input int tag, input int budget);
    int n;
    n = 0;
    while (!issued[tag]) begin
      if (n == budget) begin
        $display("op %0d did not issue within %0d cycles", tag, budget);
        abort_run();
      end
      step_cycle();
      n++;
    end
  endtask

  // the extra cycle lets the last tag leave the ctb
  task automatic drain_queue(input int budget);
    int n;
    n = 0;
    while (open_ops != 0 || credits != `IQ_SIZE) begin
      if (n == budget) begin
        $display("queue did not drain within %0d cycles", budget);
        abort_run();
      end
      step_cycle();
      n++;
    end
    step_cycle();
  endtask

  task automatic reset_state();
    issue_unit_pkg::micro_op_t none;
    none = '0;
    repeat (6) begin
      step_cycle();
      for (int k = 0; k < `ISSUE_WIDTH; k++) begin
        check_uop($sformatf("issue_uop[%0d]", k), issue_uop[k], none);
        check_uop($sformatf("complete_uop[%0d]", k), complete_uop[k], none);
      end
      check_count("credit_return", credit_return, count_t'(0));
    end
  endtask

  task automatic independent_ops();
    issue_unit_pkg::micro_op_t none;
    none = '0;
    clear_board();
    for (int t = 0; t < `DISPATCH_WIDTH; t++) begin
      stage_op(t, t, -1, -1);
    end
    step_cycle();
    step_cycle();
    for (int k = 0; k < `ISSUE_WIDTH; k++) begin
      check_uop($sformatf("issue_uop[%0d]", k), issue_uop[k], sent_uop[k]);
    end
    // slots freed by an issue return their credits in the same cycle
    check_count("credit_return", credit_return, count_t'(`ISSUE_WIDTH));
    step_cycle();
    // the op that did not fit in the first issue group
    for (int k = 0; k < `ISSUE_WIDTH; k++) begin
      check_uop($sformatf("issue_uop[%0d]", k), issue_uop[k],
                (k < `DISPATCH_WIDTH - `ISSUE_WIDTH) ? sent_uop[`ISSUE_WIDTH + k] : none);
    end
    check_count("credit_return", credit_return, count_t'(`DISPATCH_WIDTH - `ISSUE_WIDTH));
    step_cycle();
    check_count("credit_return", credit_return, count_t'(0));
    for (int k = 0; k < `ISSUE_WIDTH; k++) begin
      check_uop($sformatf("complete_uop[%0d]", k), complete_uop[k], sent_uop[k]);
    end
    step_cycle();
    check_uop("complete_uop[0]", complete_uop[0], sent_uop[`ISSUE_WIDTH]);
    drain_queue(independent_budget);
  endtask

  task automatic wakeup_timing();
    int d;
    clear_board();
    // producer, its consumer and two ready fillers in one dispatch group
    stage_op(0, 0, -1, -1);
    stage_op(1, 1, 0, -1);
    stage_op(2, 2, -1, -1);
    stage_op(3, 3, -1, -1);
    step_cycle();
    await_issue(1, wakeup_budget);
    if (issue_cycle[1] != issue_cycle[0] + `EX_LATENCY + 2) begin
      $display("consumer issued %0d cycles after its producer, expected %0d",
               issue_cycle[1] - issue_cycle[0], `EX_LATENCY + 2);
      abort_run();
    end
    stage_op(0, 4, -1, -1);
    step_cycle();
    while (!completed[4]) begin
      step_cycle();
    end
    // tag 4 is on the ctb right now
    stage_op(0, 5, 4, -1);
    d = cycle;
    step_cycle();
    await_issue(5, wakeup_budget);
    if (issue_cycle[5] != d + 2) begin
      $display("consumer loaded with a matching ctb tag issued %0d cycles after dispatch",
               issue_cycle[5] - d);
      abort_run();
    end
    drain_queue(wakeup_budget);
  endtask

  task automatic credit_flow();
    issue_unit_pkg::micro_op_t none;
    none = '0;
    clear_board();
    // all but one slot wait on the last tag, whose producer then takes the last credit
    for (int t = 0; t < `IQ_SIZE - 1; t++) begin
      stage_op(t % `DISPATCH_WIDTH, t, `IQ_SIZE - 1, -1);
      if (t % `DISPATCH_WIDTH == `DISPATCH_WIDTH - 1 || t == `IQ_SIZE - 2) begin
        step_cycle();
      end
    end
    repeat (6) begin
      step_cycle();
      for (int k = 0; k < `ISSUE_WIDTH; k++) begin
        check_uop($sformatf("issue_uop[%0d]", k), issue_uop[k], none);
      end
      check_count("credit_return", credit_return, count_t'(0));
    end
    check_count("credits", count_t'(credits), count_t'(1));
    stage_op(0, `IQ_SIZE - 1, -1, -1);
    step_cycle();
    drain_queue(credit_budget);
  endtask

  task automatic random_chains();
    int next;
    int p1;
    int p2;
    clear_board();
    next = 0;
    while (next < chain_ops) begin
      for (int lane = 0; lane < `DISPATCH_WIDTH; lane++) begin
        if (next < chain_ops && credits > 0 && $urandom % 2 == 1) begin
          p1 = (next > 0 && $urandom % 2 == 1) ? int'($urandom % next) : -1;
          p2 = (next > 0 && $urandom % 2 == 1) ? int'($urandom % next) : -1;
          stage_op(lane, next, p1, p2);
          next++;
        end
      end
      step_cycle();
    end
    drain_queue(chain_budget);
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before the tests finished", watchdog_ns);
    abort_run();
  end

  initial begin
    void'($urandom(36915));
    dispatch_uop = '0;
    cycle = 0;
    credits = `IQ_SIZE;
    open_ops = 0;
    clear_board();
    @(negedge reset);
    reset_state();
    independent_ops();
    wakeup_timing();
    credit_flow();
    random_chains();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
